//--- hdl/keygen_pkg.sv
`default_nettype none

package keygen_pkg;

    // ML-DSA modulus and Power2Round split
    localparam logic [23:0] Q = 24'd8380417;
    localparam int D = 13;
    localparam int COEFF_WIDTH = 24;
    localparam int T1_WIDTH = 10;
    localparam int T0_WIDTH = 13;

    // Hash core and seed RAM words
    localparam int WORD_WIDTH = 64;
    localparam int SEED_BITS = 256;
    localparam int SEED_ADDR_WIDTH = 6;

    // Squeeze region lengths in words
    localparam int RHO_WORDS = 4;
    localparam int RHO_PRIME_WORDS = 8;
    localparam int K_WORDS = 4;

    typedef enum logic [1:0] {
        region_rho,
        region_rho_prime,
        region_k
    } squeeze_region_t;

    // Coefficient seen either whole or as t1/t0 source fields
    typedef union packed {
        logic [COEFF_WIDTH-1:0] raw;
        struct packed {
            logic                spare;
            logic [T1_WIDTH-1:0] high;
            logic [D-1:0]        low;
        } split;
    } coeff_split_t;

endpackage

`default_nettype wire

//--- hdl/power2round.sv
`timescale 1ns/1ps
`default_nettype none

module power2round (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   coeff_valid,
    input  logic [keygen_pkg::COEFF_WIDTH-1:0]     coeff_in,
    output logic                                   t_valid,
    output logic [keygen_pkg::T1_WIDTH-1:0]        t1,
    output logic signed [keygen_pkg::T0_WIDTH-1:0] t0
);
    import keygen_pkg::*;

    localparam logic [D-1:0] HALF = D'(2 ** (D - 1));

    coeff_split_t       coeff_q;
    logic               valid_q;
    logic               round_up;
    logic [T0_WIDTH:0]  low_centered;

    // Stage 1
    always_ff @(posedge clk) begin
        coeff_q.raw <= coeff_in;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            t_valid <= 1'b0;
        end else begin
            valid_q <= coeff_valid;
            t_valid <= valid_q;
        end
    end

    // Low part above 2^(D-1) folds into a negative t0 and bumps t1
    assign round_up     = coeff_q.split.low > HALF;
    assign low_centered = round_up ? {1'b0, coeff_q.split.low} - (T0_WIDTH + 1)'(2 ** D)
                                   : {1'b0, coeff_q.split.low};

    // Stage 2
    always_ff @(posedge clk) begin
        t1 <= coeff_q.split.high + T1_WIDTH'(round_up);
        t0 <= low_centered[T0_WIDTH-1:0];
    end

    a_coeff_in_range: assert property (
        @(posedge clk) disable iff (rst) coeff_valid |-> (coeff_in < Q));

endmodule

`default_nettype wire

//--- hdl/seed_absorber.sv
`timescale 1ns/1ps
`default_nettype none

module seed_absorber #(
    parameter int K = 8,
    parameter int L = 7
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              absorb_start,
    input  logic [keygen_pkg::SEED_BITS-1:0]  xi,
    output logic [keygen_pkg::WORD_WIDTH-1:0] absorb_data,
    output logic                              absorb_valid,
    output logic                              absorb_last,
    input  logic                              absorb_ready,
    output logic                              absorb_done
);
    import keygen_pkg::*;

    localparam int XI_WORDS  = SEED_BITS / WORD_WIDTH;
    localparam int SEL_WIDTH = $clog2(XI_WORDS);
    localparam int CNT_WIDTH = $clog2(XI_WORDS + 1);
    localparam logic [CNT_WIDTH-1:0] LAST_CNT = CNT_WIDTH'(XI_WORDS);

    logic [XI_WORDS-1:0][WORD_WIDTH-1:0] xi_words;
    logic [CNT_WIDTH-1:0]                word_cnt;
    logic [WORD_WIDTH-1:0]               kl_word;
    logic                                take;

    // Parameter bytes follow the seed with K above L
    assign kl_word = {{(WORD_WIDTH - 16){1'b0}}, 8'(K), 8'(L)};
    assign take    = absorb_valid && absorb_ready;

    always_ff @(posedge clk) begin
        if (absorb_start) begin
            xi_words <= xi;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            word_cnt     <= '0;
            absorb_valid <= 1'b0;
            absorb_done  <= 1'b0;
        end else begin
            absorb_done <= 1'b0;
            if (absorb_start) begin
                word_cnt     <= '0;
                absorb_valid <= 1'b1;
            end else if (take) begin
                if (word_cnt == LAST_CNT) begin
                    word_cnt     <= '0;
                    absorb_valid <= 1'b0;
                    absorb_done  <= 1'b1;
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end
        end
    end

    // Low seed word first and the counter only moves on a take
    assign absorb_data = (word_cnt == LAST_CNT) ? kl_word
                                                : xi_words[word_cnt[SEL_WIDTH-1:0]];
    assign absorb_last = absorb_valid && (word_cnt == LAST_CNT);

    a_data_stable_on_stall: assert property (
        @(posedge clk) disable iff (rst)
        (absorb_valid && !absorb_ready) |=> (absorb_valid && $stable(absorb_data)));

endmodule

`default_nettype wire

//--- hdl/squeeze_writer.sv
`timescale 1ns/1ps
`default_nettype none

module squeeze_writer #(
    parameter int RHO_BASE       = 0,
    parameter int RHO_PRIME_BASE = 8,
    parameter int K_BASE         = 16
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   squeeze_en,
    input  keygen_pkg::squeeze_region_t            region,
    input  logic [keygen_pkg::WORD_WIDTH-1:0]      squeeze_data,
    input  logic                                   squeeze_valid,
    output logic                                   squeeze_ready,
    output logic                                   seed_we,
    output logic [keygen_pkg::SEED_ADDR_WIDTH-1:0] seed_addr,
    output logic [keygen_pkg::WORD_WIDTH-1:0]      seed_din,
    output logic                                   region_done
);
    import keygen_pkg::*;

    // Widest region sets the index width
    localparam int IDX_WIDTH = $clog2(RHO_PRIME_WORDS);

    logic [IDX_WIDTH-1:0]       word_idx;
    logic [IDX_WIDTH-1:0]       last_idx;
    logic [SEED_ADDR_WIDTH-1:0] base_addr;
    logic                       take;

    always_comb begin
        case (region)
            region_rho_prime: begin
                base_addr = SEED_ADDR_WIDTH'(RHO_PRIME_BASE);
                last_idx  = IDX_WIDTH'(RHO_PRIME_WORDS - 1);
            end
            region_k: begin
                base_addr = SEED_ADDR_WIDTH'(K_BASE);
                last_idx  = IDX_WIDTH'(K_WORDS - 1);
            end
            default: begin
                base_addr = SEED_ADDR_WIDTH'(RHO_BASE);
                last_idx  = IDX_WIDTH'(RHO_WORDS - 1);
            end
        endcase
    end

    // Pause one cycle after a region's last take while the region select moves on
    assign squeeze_ready = squeeze_en && !region_done;
    assign take          = squeeze_valid && squeeze_ready;

    always_ff @(posedge clk) begin
        if (take) begin
            seed_din  <= squeeze_data;
            seed_addr <= base_addr + SEED_ADDR_WIDTH'(word_idx);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            word_idx    <= '0;
            seed_we     <= 1'b0;
            region_done <= 1'b0;
        end else begin
            seed_we     <= take;
            region_done <= 1'b0;
            if (take) begin
                if (word_idx == last_idx) begin
                    word_idx    <= '0;
                    region_done <= 1'b1;
                end else begin
                    word_idx <= word_idx + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/keygen_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module keygen_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    output logic                        hash_init,
    output logic                        absorb_start,
    input  logic                        absorb_done,
    output logic                        squeeze_en,
    output keygen_pkg::squeeze_region_t region,
    input  logic                        region_done,
    output logic                        done
);
    import keygen_pkg::*;

    localparam logic [2:0] ST_IDLE              = 3'd0;
    localparam logic [2:0] ST_INIT              = 3'd1;
    localparam logic [2:0] ST_ABSORB            = 3'd2;
    localparam logic [2:0] ST_SQUEEZE_RHO       = 3'd3;
    localparam logic [2:0] ST_SQUEEZE_RHO_PRIME = 3'd4;
    localparam logic [2:0] ST_SQUEEZE_K         = 3'd5;
    localparam logic [2:0] ST_FINISH            = 3'd6;

    logic [2:0] state;
    logic [2:0] next_state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Start is only looked at in idle, so a start while busy is dropped
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    next_state = ST_INIT;
                end
            end
            ST_INIT: next_state = ST_ABSORB;
            ST_ABSORB: begin
                if (absorb_done) begin
                    next_state = ST_SQUEEZE_RHO;
                end
            end
            ST_SQUEEZE_RHO: begin
                if (region_done) begin
                    next_state = ST_SQUEEZE_RHO_PRIME;
                end
            end
            ST_SQUEEZE_RHO_PRIME: begin
                if (region_done) begin
                    next_state = ST_SQUEEZE_K;
                end
            end
            ST_SQUEEZE_K: begin
                if (region_done) begin
                    next_state = ST_FINISH;
                end
            end
            default: next_state = ST_IDLE;
        endcase
    end

    // Core is cleared while the absorber loads xi
    assign hash_init    = (state == ST_INIT);
    assign absorb_start = (state == ST_INIT);
    assign done         = (state == ST_FINISH);

    assign squeeze_en = (state == ST_SQUEEZE_RHO) || (state == ST_SQUEEZE_RHO_PRIME)
                        || (state == ST_SQUEEZE_K);

    always_comb begin
        case (state)
            ST_SQUEEZE_RHO_PRIME: region = region_rho_prime;
            ST_SQUEEZE_K:         region = region_k;
            default:              region = region_rho;
        endcase
    end

    // Writer only finishes a region while squeezing is enabled
    a_region_done_in_squeeze: assert property (
        @(posedge clk) disable iff (rst) region_done |-> squeeze_en);

    a_hash_init_single: assert property (
        @(posedge clk) disable iff (rst) hash_init |=> !hash_init);

endmodule

`default_nettype wire

//--- hdl/keygen_front.sv
`timescale 1ns/1ps
`default_nettype none

module keygen_front #(
    parameter int K              = 8,
    parameter int L              = 7,
    parameter int RHO_BASE       = 0,
    parameter int RHO_PRIME_BASE = 8,
    parameter int K_BASE         = 16
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   start,
    input  logic [keygen_pkg::SEED_BITS-1:0]       xi,
    output logic                                   done,
    output logic                                   hash_init,
    output logic [keygen_pkg::WORD_WIDTH-1:0]      absorb_data,
    output logic                                   absorb_valid,
    output logic                                   absorb_last,
    input  logic                                   absorb_ready,
    input  logic [keygen_pkg::WORD_WIDTH-1:0]      squeeze_data,
    input  logic                                   squeeze_valid,
    output logic                                   squeeze_ready,
    output logic                                   seed_we,
    output logic [keygen_pkg::SEED_ADDR_WIDTH-1:0] seed_addr,
    output logic [keygen_pkg::WORD_WIDTH-1:0]      seed_din,
    input  logic                                   coeff_valid,
    input  logic [keygen_pkg::COEFF_WIDTH-1:0]     coeff_in,
    output logic                                   t_valid,
    output logic [keygen_pkg::T1_WIDTH-1:0]        t1,
    output logic signed [keygen_pkg::T0_WIDTH-1:0] t0
);
    import keygen_pkg::*;

    logic            absorb_start;
    logic            absorb_done;
    logic            squeeze_en;
    squeeze_region_t region;
    logic            region_done;

    keygen_ctrl i_keygen_ctrl (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .hash_init    (hash_init),
        .absorb_start (absorb_start),
        .absorb_done  (absorb_done),
        .squeeze_en   (squeeze_en),
        .region       (region),
        .region_done  (region_done),
        .done         (done)
    );

    seed_absorber #(
        .K (K),
        .L (L)
    ) i_seed_absorber (
        .clk          (clk),
        .rst          (rst),
        .absorb_start (absorb_start),
        .xi           (xi),
        .absorb_data  (absorb_data),
        .absorb_valid (absorb_valid),
        .absorb_last  (absorb_last),
        .absorb_ready (absorb_ready),
        .absorb_done  (absorb_done)
    );

    squeeze_writer #(
        .RHO_BASE       (RHO_BASE),
        .RHO_PRIME_BASE (RHO_PRIME_BASE),
        .K_BASE         (K_BASE)
    ) i_squeeze_writer (
        .clk           (clk),
        .rst           (rst),
        .squeeze_en    (squeeze_en),
        .region        (region),
        .squeeze_data  (squeeze_data),
        .squeeze_valid (squeeze_valid),
        .squeeze_ready (squeeze_ready),
        .seed_we       (seed_we),
        .seed_addr     (seed_addr),
        .seed_din      (seed_din),
        .region_done   (region_done)
    );

    power2round i_power2round (
        .clk         (clk),
        .rst         (rst),
        .coeff_valid (coeff_valid),
        .coeff_in    (coeff_in),
        .t_valid     (t_valid),
        .t1          (t1),
        .t0          (t0)
    );

endmodule

`default_nettype wire

//--- sim/keygen_ref.svh
`ifndef KEYGEN_REF_SVH
`define KEYGEN_REF_SVH

// Absorb order is xi from the low word up, then the K/L word
function automatic logic [63:0] absorb_word_at(input logic [255:0] seed_xi, input int idx,
                                               input int k, input int l);
    if (idx < 4) begin
        return seed_xi[idx*64 +: 64];
    end
    return {48'd0, k[7:0], l[7:0]};
endfunction

// rho in words 0-3, rho' in 4-11, K in 12-15
function automatic logic [5:0] region_addr(input int i);
    int a;
    if (i < 4) begin
        a = RHO_BASE + i;
    end else if (i < 12) begin
        a = RHO_PRIME_BASE + (i - 4);
    end else begin
        a = K_BASE + (i - 12);
    end
    return a[5:0];
endfunction

function automatic logic [9:0] rounded_high(input int r);
    int low;
    int hi;
    low = r % 8192;
    hi  = (r >> 13) + ((low > 4096) ? 1 : 0);
    return hi[9:0];
endfunction

// Centered remainder kept as a 13-bit pattern
function automatic logic [12:0] centered_low(input int r);
    int low;
    low = r % 8192;
    if (low > 4096) begin
        low = low - 8192;
    end
    return low[12:0];
endfunction

`endif

//--- sim/tb_keygen_front.sv
`timescale 1ns/1ps
`default_nettype none

module tb_keygen_front;

    localparam int K              = 8;
    localparam int L              = 7;
    localparam int RHO_BASE       = 0;
    localparam int RHO_PRIME_BASE = 8;
    localparam int K_BASE         = 16;
    localparam int RUNS           = 3;
    localparam int RUN_CYCLES     = 200;
    localparam int P2R_CYCLES     = 400;
    localparam int MAX_CYCLES     = RUNS * RUN_CYCLES + P2R_CYCLES;
    localparam int RANDOM_COEFFS  = 300;

    `include "keygen_ref.svh"

    logic clk;
    logic rst;
    logic start;
    logic [255:0] xi;
    logic done;
    logic hash_init;
    logic [63:0] absorb_data;
    logic absorb_valid;
    logic absorb_last;
    logic absorb_ready;
    logic [63:0] squeeze_data;
    logic squeeze_valid;
    logic squeeze_ready;
    logic seed_we;
    logic [5:0] seed_addr;
    logic [63:0] seed_din;
    logic coeff_valid;
    logic [23:0] coeff_in;
    logic t_valid;
    logic [9:0] t1;
    logic signed [12:0] t0;

    int seed;
    int cycle = 0;
    int errors = 0;
    int checks = 0;
    logic [63:0] absorbed_log[$];
    logic [63:0] squeeze_q[$];
    int squeeze_cycle_q[$];
    int coeff_q[$];
    int coeff_cycle_q[$];

    keygen_front #(
        .K              (K),
        .L              (L),
        .RHO_BASE       (RHO_BASE),
        .RHO_PRIME_BASE (RHO_PRIME_BASE),
        .K_BASE         (K_BASE)
    ) i_keygen_front (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .xi            (xi),
        .done          (done),
        .hash_init     (hash_init),
        .absorb_data   (absorb_data),
        .absorb_valid  (absorb_valid),
        .absorb_last   (absorb_last),
        .absorb_ready  (absorb_ready),
        .squeeze_data  (squeeze_data),
        .squeeze_valid (squeeze_valid),
        .squeeze_ready (squeeze_ready),
        .seed_we       (seed_we),
        .seed_addr     (seed_addr),
        .seed_din      (seed_din),
        .coeff_valid   (coeff_valid),
        .coeff_in      (coeff_in),
        .t_valid       (t_valid),
        .t1            (t1),
        .t0            (t0)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic print_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
        $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        errors++;
    endtask

    task automatic flag_failure(input string msg);
        $display("%s (cycle %0d)", msg, cycle);
        errors++;
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    // Hash core model with random stalls and gaps
    always @(posedge clk) begin
        if (rst) begin
            absorb_ready  <= 1'b0;
            squeeze_valid <= 1'b0;
            squeeze_data  <= '0;
        end else begin
            absorb_ready <= ($random(seed) & 3) != 0;
            if (absorb_valid && absorb_ready) begin
                absorbed_log.push_back(absorb_data);
            end
            if (squeeze_valid && squeeze_ready) begin
                squeeze_q.push_back(squeeze_data);
                squeeze_cycle_q.push_back(cycle);
            end
            // Offered word is held until it is taken
            if (!squeeze_valid || squeeze_ready) begin
                squeeze_valid <= ($random(seed) & 3) != 0;
                squeeze_data  <= {$random(seed), $random(seed)};
            end
        end
    end

    logic         busy;
    logic         prev_stall;
    logic         prev_last_write;
    logic [63:0]  prev_data;
    logic [255:0] run_xi;
    int absorb_idx;
    int write_idx;
    int init_count;
    int done_count;
    int absorb_total;
    int write_total;
    int p2r_count;

    always @(posedge clk) begin
        int r;
        int c;
        logic [63:0] word;
        if (rst) begin
            busy = 1'b0;
            prev_stall = 1'b0;
            prev_last_write = 1'b0;
            prev_data = '0;
            run_xi = '0;
            absorb_idx = 0;
            write_idx = 0;
            init_count = 0;
            done_count = 0;
            absorb_total = 0;
            write_total = 0;
            p2r_count = 0;
        end else begin
            // Power2Round results against the input two cycles back
            if (t_valid) begin
                if (coeff_q.size() == 0) begin
                    flag_failure("t_valid came without a pending coefficient");
                end else begin
                    r = coeff_q.pop_front();
                    c = coeff_cycle_q.pop_front();
                    checks++;
                    if (cycle != c + 2) begin
                        flag_failure("Power2Round result did not come two cycles after input");
                    end
                    if (t1 !== rounded_high(r)) begin
                        print_mismatch("t1", 64'(t1), 64'(rounded_high(r)));
                    end
                    if (t0 !== centered_low(r)) begin
                        print_mismatch("t0", {51'd0, t0}, 64'(centered_low(r)));
                    end
                    p2r_count++;
                end
            end
            if (coeff_valid) begin
                coeff_q.push_back(int'(coeff_in));
                coeff_cycle_q.push_back(cycle);
            end

            if (hash_init) begin
                if (busy) begin
                    flag_failure("hash_init came while a run was still busy");
                end
                busy = 1'b1;
                init_count++;
                absorb_idx = 0;
                write_idx = 0;
                run_xi = xi;
            end

            if (prev_stall && (!absorb_valid || absorb_data !== prev_data)) begin
                flag_failure("absorb word changed or dropped during a stall");
            end
            if (absorb_valid && absorb_ready) begin
                checks++;
                if (!busy || absorb_idx > 4) begin
                    flag_failure("absorb word taken outside the five-word absorb");
                end else begin
                    word = absorb_word_at(run_xi, absorb_idx, K, L);
                    if (absorb_data !== word) begin
                        print_mismatch("absorb_data", absorb_data, word);
                    end
                    if (absorb_last !== (absorb_idx == 4)) begin
                        print_mismatch("absorb_last", 64'(absorb_last), 64'(absorb_idx == 4));
                    end
                    absorb_idx++;
                    absorb_total++;
                end
            end
            prev_stall = absorb_valid && !absorb_ready;
            prev_data = absorb_data;

            if (seed_we) begin
                checks++;
                if (squeeze_q.size() == 0) begin
                    flag_failure("seed write without a squeezed word");
                end else begin
                    word = squeeze_q.pop_front();
                    c = squeeze_cycle_q.pop_front();
                    if (cycle != c + 1) begin
                        flag_failure("seed write did not follow its squeeze by one cycle");
                    end
                    if (write_idx > 15) begin
                        flag_failure("more than sixteen seed writes in one run");
                    end
                    if (seed_addr !== region_addr(write_idx)) begin
                        print_mismatch("seed_addr", 64'(seed_addr),
                                       64'(region_addr(write_idx)));
                    end
                    if (seed_din !== word) begin
                        print_mismatch("seed_din", seed_din, word);
                    end
                    write_idx++;
                    write_total++;
                end
            end
            if (squeeze_cycle_q.size() > 0 && squeeze_cycle_q[0] < cycle) begin
                flag_failure("squeezed word was never written to seed RAM");
                void'(squeeze_q.pop_front());
                void'(squeeze_cycle_q.pop_front());
            end

            if (done && !prev_last_write) begin
                flag_failure("done came without a sixteenth seed write just before");
            end
            if (!done && prev_last_write) begin
                flag_failure("done missing one cycle after the sixteenth seed write");
            end
            if (done) begin
                done_count++;
                busy = 1'b0;
            end
            prev_last_write = seed_we && (write_idx == 16);
        end
    end

    task automatic run_keygen(input bit busy_start);
        @(posedge clk);
        xi <= {$random(seed), $random(seed), $random(seed), $random(seed),
               $random(seed), $random(seed), $random(seed), $random(seed)};
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        // Second start lands mid-run and must be ignored
        if (busy_start) begin
            repeat (12) @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
        end
        while (done !== 1'b1) @(posedge clk);
        repeat (3) @(posedge clk);
    endtask

    task automatic feed_coefficients();
        logic [23:0] corner[6];
        logic [31:0] rnd;
        corner = '{24'd0, 24'd4096, 24'd4097, 24'd8191, 24'd8192, 24'd8380416};
        foreach (corner[i]) begin
            @(posedge clk);
            coeff_valid <= 1'b1;
            coeff_in    <= corner[i];
        end
        for (int i = 0; i < RANDOM_COEFFS; i++) begin
            rnd = $random(seed);
            rnd = rnd % 32'd8380417;
            @(posedge clk);
            coeff_valid <= 1'b1;
            coeff_in    <= rnd[23:0];
        end
        @(posedge clk);
        coeff_valid <= 1'b0;
    endtask

    initial begin
        seed = 85160;
        rst = 1'b1;
        start = 1'b0;
        xi = '0;
        coeff_valid = 1'b0;
        coeff_in = '0;
        absorb_ready = 1'b0;
        squeeze_valid = 1'b0;
        squeeze_data = '0;
        repeat (8) @(posedge clk);
        if ({hash_init, absorb_valid, squeeze_ready, seed_we, done, t_valid} !== 6'b0) begin
            flag_failure("control outputs not low during reset");
        end
        rst <= 1'b0;
        for (int run = 0; run < RUNS; run++) begin
            run_keygen(run == 1);
        end
        feed_coefficients();
        repeat (6) @(posedge clk);

        if (init_count != RUNS || done_count != RUNS) begin
            flag_failure("hash_init or done count differs from the number of runs");
        end
        if (absorb_total != 5 * RUNS || absorbed_log.size() != 5 * RUNS) begin
            flag_failure("wrong number of absorbed words");
        end
        if (write_total != 16 * RUNS) begin
            flag_failure("wrong number of seed writes");
        end
        if (p2r_count != RANDOM_COEFFS + 6 || coeff_q.size() != 0) begin
            flag_failure("Power2Round results missing");
        end
        $display("Summary: %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- keygen_front.f
+incdir+sim
hdl/keygen_pkg.sv
hdl/power2round.sv
hdl/seed_absorber.sv
hdl/squeeze_writer.sv
hdl/keygen_ctrl.sv
hdl/keygen_front.sv
sim/tb_keygen_front.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_keygen_front
FILELIST  ?= keygen_front.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
